//--- icache_pkg.sv
// Geometry of a direct-mapped instruction cache, 16 lines of 4 words.
// Addresses are byte addresses, and the two lowest bits are ignored.
// Instructions are 32-bit aligned words.

package icache_pkg;

    // ------------------------------------------------------------------------
    // Cache geometry.
    // ------------------------------------------------------------------------
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int SETS       = 16;

    // Byte offset inside a word.
    localparam int BYTE_W     = 2;

    // Address fields, from the bottom up: byte, word offset, index, tag.
    localparam int OFFSET_W   = $clog2(LINE_WORDS);
    localparam int INDEX_W    = $clog2(SETS);
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;

    // ------------------------------------------------------------------------
    // Width types.
    // ------------------------------------------------------------------------
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // Full cache line, word 0 in the lowest bits.
    typedef word_t [LINE_WORDS-1:0] line_t;

    // ------------------------------------------------------------------------
    // Structs.
    // ------------------------------------------------------------------------

    // Decoded fetch request.
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } cache_req_t;

    // Burst request toward memory, always line aligned.
    typedef struct packed {
        addr_t addr;
    } mem_req_t;

endpackage

//--- icache_req_reg.sv
// Fetch request register. A new request is taken only while o_busy is low,
// requests made while busy are dropped without notice.
// o_start_check is the accept strobe itself, in the same cycle as i_req.

`timescale 1ns/1ps

module icache_req_reg
    import icache_pkg::*;
(
    // Clock and reset.
    input  logic       clk,
    input  logic       arst,

    // Fetch side.
    input  logic       i_req,
    input  addr_t      i_addr,

    // Response seen by the fetch side, ends the transaction.
    input  logic       i_rsp_valid,

    // Toward FSM, store and fill unit.
    output logic       o_start_check,
    output logic       o_busy,
    output cache_req_t o_req
);

    logic       busy_q;
    logic       accept;
    cache_req_t req_d;
    cache_req_t req_q;

    assign accept = i_req & ~busy_q;

    // Split the byte address into its fields.
    assign req_d.tag    = i_addr[ADDR_W-1 -: TAG_W];
    assign req_d.index  = i_addr[BYTE_W+OFFSET_W +: INDEX_W];
    assign req_d.offset = i_addr[BYTE_W +: OFFSET_W];

    // Busy from the accept edge to the end of the response cycle.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (i_rsp_valid) begin
            busy_q <= 1'b0;
        end
    end

    // Held until the response.
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_d;
        end
    end

    assign o_start_check = accept;
    assign o_busy        = busy_q;
    assign o_req         = req_q;

endmodule

//--- icache_fsm.sv
// Cache control FSM with the states IDLE, COMPARE_TAG and ALLOCATE.
// o_stall depends on i_hit in COMPARE_TAG, and o_instr_write_en on i_r_last
// in ALLOCATE, so both follow their inputs in the same cycle.

`timescale 1ns/1ps

module icache_fsm (
    // Clock and reset.
    input  logic clk,
    input  logic arst,

    // Status inputs.
    input  logic i_start_check,
    input  logic i_hit,
    input  logic i_r_last,

    // Controls.
    output logic o_stall,
    output logic o_instr_write_en,
    output logic o_start_read
);

    // ------------------------------------------------------------------------
    // State register.
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE        = 2'b00,
        COMPARE_TAG = 2'b01,
        ALLOCATE    = 2'b10
    } state_t;

    state_t state_q;
    state_t state_d;

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------------
    // Next state.
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_start_check) begin
                    state_d = COMPARE_TAG;
                end
            end
            COMPARE_TAG: begin
                state_d = i_hit ? IDLE : ALLOCATE;
            end
            ALLOCATE: begin
                // Line is written on this edge, then the tag is checked again.
                if (i_r_last) begin
                    state_d = COMPARE_TAG;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // ------------------------------------------------------------------------
    // Outputs.
    // ------------------------------------------------------------------------
    always_comb begin
        o_stall          = 1'b1;
        o_start_read     = 1'b0;
        o_instr_write_en = 1'b0;
        case (state_q)
            COMPARE_TAG: begin
                o_stall = ~i_hit;
            end
            ALLOCATE: begin
                o_start_read     = 1'b1;
                o_instr_write_en = i_r_last;
            end
            default: o_stall = 1'b1;
        endcase
    end

endmodule

//--- icache_store.sv
// Tag and data arrays of the cache, indexed by the held request.
// No lookup hits after reset until its line is filled.
// A line write replaces line, tag and valid bit together on one edge.

`timescale 1ns/1ps

module icache_store
    import icache_pkg::*;
(
    // Clock and reset.
    input  logic       clk,
    input  logic       arst,

    // Held request.
    input  cache_req_t i_req,

    // Line fill.
    input  logic       i_line_we,
    input  line_t      i_line,

    // Lookup result.
    output logic       o_hit,
    output word_t      o_instr
);

    // ------------------------------------------------------------------------
    // Storage.
    // ------------------------------------------------------------------------
    logic [SETS-1:0] valid_q;
    tag_t            tag_mem  [SETS];
    line_t           data_mem [SETS];

    // Entry selected by the request.
    logic            set_valid;
    tag_t            set_tag;
    line_t           set_line;

    // Valid bits are set by a fill and cleared only by reset.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            valid_q <= '0;
        end else if (i_line_we) begin
            valid_q[i_req.index] <= 1'b1;
        end
    end

    // Tag and data arrays.
    always_ff @(posedge clk) begin
        if (i_line_we) begin
            tag_mem[i_req.index]  <= i_req.tag;
            data_mem[i_req.index] <= i_line;
        end
    end

    // ------------------------------------------------------------------------
    // Lookup.
    // ------------------------------------------------------------------------
    assign set_valid = valid_q[i_req.index];
    assign set_tag   = tag_mem[i_req.index];
    assign set_line  = data_mem[i_req.index];

    // Hit compare.
    assign o_hit = set_valid & (set_tag == i_req.tag);

    // Word select inside the line.
    assign o_instr = set_line[i_req.offset];

endmodule

//--- icache_fill.sv
// Line fill from memory. One burst request per ALLOCATE visit.
// Memory must return exactly LINE_WORDS beats, lowest word first,
// with i_mem_rlast on the last one. Gaps between beats are allowed.

`timescale 1ns/1ps

module icache_fill
    import icache_pkg::*;
(
    // Clock and reset.
    input  logic       clk,
    input  logic       arst,

    // From FSM and request register.
    input  logic       i_start_read,
    input  cache_req_t i_req,

    // Memory read data.
    input  logic       i_mem_rvalid,
    input  word_t      i_mem_rdata,
    input  logic       i_mem_rlast,

    // Memory request.
    output logic       o_mem_req,
    output addr_t      o_mem_addr,

    // Assembled line for the store.
    output line_t      o_line,
    output logic       o_r_last
);

    logic     issued_q;
    offset_t  beat_q;
    line_t    line_q;
    mem_req_t burst;

    // ------------------------------------------------------------------------
    // Request side.
    // ------------------------------------------------------------------------

    // Strobe on the first cycle of start_read only.
    assign o_mem_req = i_start_read & ~issued_q;

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            issued_q <= 1'b0;
        end else if (!i_start_read) begin
            issued_q <= 1'b0;
        end else if (o_mem_req) begin
            issued_q <= 1'b1;
        end
    end

    // Line aligned burst address.
    assign burst.addr = {i_req.tag, i_req.index, {(OFFSET_W + BYTE_W){1'b0}}};
    assign o_mem_addr = burst.addr;

    // ------------------------------------------------------------------------
    // Beat collection.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            beat_q <= '0;
        end else if (!i_start_read || (i_mem_rvalid && i_mem_rlast)) begin
            beat_q <= '0;
        end else if (i_mem_rvalid) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    // Current beat merged in so the line is complete on the last beat.
    always_comb begin
        o_line = line_q;
        if (i_mem_rvalid) begin
            o_line[beat_q] = i_mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_mem_rvalid) begin
            line_q <= o_line;
        end
    end

    assign o_r_last = i_mem_rvalid & i_mem_rlast;

endmodule

//--- icache_top.sv
// Direct-mapped instruction cache top level.
// One request at a time; i_req is honoured only while o_busy is low.
// Hit latency is one cycle, a miss waits for a full line burst.

`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    // Clock and reset.
    input  logic  clk,
    input  logic  arst,

    // Fetch interface.
    input  logic  i_req,
    input  addr_t i_addr,
    output logic  o_busy,
    output logic  o_rsp_valid,
    output word_t o_rsp_instr,

    // Memory interface.
    output logic  o_mem_req,
    output addr_t o_mem_addr,
    input  logic  i_mem_rvalid,
    input  word_t i_mem_rdata,
    input  logic  i_mem_rlast
);

    cache_req_t s_req;
    logic       s_start_check;
    logic       s_hit;
    logic       s_stall;
    logic       s_start_read;
    logic       s_line_we;
    logic       s_r_last;
    line_t      s_line;

    // Response whenever the FSM is not stalling.
    assign o_rsp_valid = ~s_stall;

    // ------------------------------------------------------------------------
    // Input side and control.
    // ------------------------------------------------------------------------
    icache_req_reg u_req_reg (
        .clk           (clk),
        .arst          (arst),
        .i_req         (i_req),
        .i_addr        (i_addr),
        .i_rsp_valid   (o_rsp_valid),
        .o_start_check (s_start_check),
        .o_busy        (o_busy),
        .o_req         (s_req)
    );

    icache_fsm u_fsm (
        .clk              (clk),
        .arst             (arst),
        .i_start_check    (s_start_check),
        .i_hit            (s_hit),
        .i_r_last         (s_r_last),
        .o_stall          (s_stall),
        .o_instr_write_en (s_line_we),
        .o_start_read     (s_start_read)
    );

    // ------------------------------------------------------------------------
    // Arrays and memory side.
    // ------------------------------------------------------------------------
    icache_store u_store (
        .clk       (clk),
        .arst      (arst),
        .i_req     (s_req),
        .i_line_we (s_line_we),
        .i_line    (s_line),
        .o_hit     (s_hit),
        .o_instr   (o_rsp_instr)
    );

    icache_fill u_fill (
        .clk          (clk),
        .arst         (arst),
        .i_start_read (s_start_read),
        .i_req        (s_req),
        .i_mem_rvalid (i_mem_rvalid),
        .i_mem_rdata  (i_mem_rdata),
        .i_mem_rlast  (i_mem_rlast),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .o_line       (s_line),
        .o_r_last     (s_r_last)
    );

endmodule

//--- icache_chk.sv
// Protocol checks on the cache ports, bound into icache_top.
// Assumes one outstanding fetch at a time.

`timescale 1ns/1ps

module icache_chk (
    input logic clk,
    input logic arst,
    input logic i_mem_req,
    input logic i_rsp_valid,
    input logic i_busy
);

    // ------------------------------------------------------------------------
    // Strobes.
    // ------------------------------------------------------------------------

    // One request strobe per burst.
    a_mem_req_pulse: assert property (@(posedge clk) disable iff (arst)
        i_mem_req |=> !i_mem_req)
        else $error("o_mem_req high in two consecutive cycles");

    a_rsp_pulse: assert property (@(posedge clk) disable iff (arst)
        i_rsp_valid |=> !i_rsp_valid)
        else $error("o_rsp_valid high in two consecutive cycles");

    // ------------------------------------------------------------------------
    // Busy flag.
    // ------------------------------------------------------------------------

    // Busy ends exactly with the response.
    a_busy_fall: assert property (@(posedge clk) disable iff (arst)
        $fell(i_busy) |-> $past(i_rsp_valid))
        else $error("o_busy fell without a response in the cycle before");

    a_busy_after_rsp: assert property (@(posedge clk) disable iff (arst)
        i_rsp_valid |=> !i_busy)
        else $error("o_busy still high after the response");

    a_rsp_while_busy: assert property (@(posedge clk) disable iff (arst)
        i_rsp_valid |-> i_busy)
        else $error("o_rsp_valid without an accepted request");

endmodule

//--- icache_tb.sv
// Testbench for the instruction cache. A memory model with random beat gaps
// and a shadow tag model predict every response.
// Runs stop at the first error or at a fixed cycle limit.

`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam int    RESET_CYCLES   = 8;
    localparam int    STREAM_LEN     = 30;
    localparam int    TIMEOUT_CYCLES = 40 * 40;
    localparam int    WORD_BYTES     = WORD_W / 8;
    localparam int    LINE_BYTES     = LINE_WORDS * WORD_BYTES;
    localparam word_t MEM_PATTERN    = 32'h5a5a0000;

    logic   clk;
    logic   arst;
    logic   i_req;
    addr_t  i_addr;
    logic   o_busy;
    logic   o_rsp_valid;
    word_t  o_rsp_instr;
    logic   o_mem_req;
    addr_t  o_mem_addr;
    logic   i_mem_rvalid;
    word_t  i_mem_rdata;
    logic   i_mem_rlast;

    // Prediction for the request in flight.
    logic   exp_hit;
    word_t  exp_instr;
    addr_t  exp_line;
    logic   started;

    // Shadow tag array.
    logic   model_valid [SETS];
    tag_t   model_tag   [SETS];

    int     mem_reqs;
    int     misses;
    int     cycles;
    integer seed = 32'he1d787eb;
    addr_t  stream [STREAM_LEN];

    icache_top u_icache_top (.*);

    bind icache_top icache_chk u_chk (
        .clk         (clk),
        .arst        (arst),
        .i_mem_req   (o_mem_req),
        .i_rsp_valid (o_rsp_valid),
        .i_busy      (o_busy)
    );

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %0t ns: %s = %h, expected %h", $time, name, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // Memory contents are the word address xor a fixed pattern.
    function automatic word_t mem_word(input addr_t addr);
        return {addr[ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}} ^ MEM_PATTERN;
    endfunction

    // Line number modulo the number of sets.
    function automatic index_t set_of(input addr_t addr);
        return index_t'((addr / LINE_BYTES) % SETS);
    endfunction

    // Line number divided by the number of sets.
    function automatic tag_t tag_of(input addr_t addr);
        return tag_t'(addr / (LINE_BYTES * SETS));
    endfunction

    // ------------------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------------------
    a_rsp_instr: assert property (@(posedge clk) disable iff (arst)
        o_rsp_valid |-> o_rsp_instr == exp_instr)
        else report_mismatch("o_rsp_instr", o_rsp_instr, exp_instr);

    a_mem_addr: assert property (@(posedge clk) disable iff (arst)
        o_mem_req |-> o_mem_addr == exp_line)
        else report_mismatch("o_mem_addr", o_mem_addr, exp_line);

    a_no_fill_on_hit: assert property (@(posedge clk) disable iff (arst)
        o_mem_req |-> !exp_hit)
        else report_error("memory request for a fetch that should hit");

    a_fill_timing: assert property (@(posedge clk) disable iff (arst)
        o_mem_req |-> $past(o_busy) && !$past(o_busy, 2))
        else report_error("memory request not in the first fill cycle");

    a_hit_latency: assert property (@(posedge clk) disable iff (arst)
        (i_req && !o_busy && exp_hit) |=> o_rsp_valid)
        else report_error("hit did not respond one cycle after acceptance");

    a_miss_wait: assert property (@(posedge clk) disable iff (arst)
        (i_req && !o_busy && !exp_hit) |=> !o_rsp_valid)
        else report_error("miss answered before the line was filled");

    a_quiet_reset: assert property (@(posedge clk) disable iff (arst)
        !started |-> !o_busy && !o_rsp_valid && !o_mem_req)
        else report_error("outputs active before the first request");

    // ------------------------------------------------------------------------
    // Clock, memory model and watchdog.
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic serve_burst(input addr_t base);
        int beat;
        int gap;
        for (beat = 0; beat < LINE_WORDS; beat++) begin
            gap = $random(seed) & 3;
            repeat (gap) begin
                @(negedge clk);
                i_mem_rvalid = 1'b0;
                i_mem_rlast  = 1'b0;
            end
            @(negedge clk);
            i_mem_rvalid = 1'b1;
            i_mem_rdata  = mem_word(base + addr_t'(beat * WORD_BYTES));
            i_mem_rlast  = (beat == LINE_WORDS - 1);
        end
        @(negedge clk);
        i_mem_rvalid = 1'b0;
        i_mem_rlast  = 1'b0;
    endtask

    initial begin
        i_mem_rvalid = 1'b0;
        i_mem_rdata  = '0;
        i_mem_rlast  = 1'b0;
        mem_reqs     = 0;
        forever begin
            @(negedge clk);
            if (o_mem_req) begin
                mem_reqs++;
                serve_burst(o_mem_addr);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        report_error("timeout, the cycle limit was reached");
    end

    // ------------------------------------------------------------------------
    // Stimulus.
    // ------------------------------------------------------------------------
    // One fetch predicted by the shadow tags and waited on until o_rsp_valid.
    task automatic fetch(input addr_t addr);
        int reqs_before;
        @(negedge clk);
        exp_hit = model_valid[set_of(addr)] && (model_tag[set_of(addr)] == tag_of(addr));
        if (!exp_hit) begin
            misses++;
            model_valid[set_of(addr)] = 1'b1;
            model_tag[set_of(addr)]   = tag_of(addr);
        end
        exp_instr   = mem_word(addr);
        exp_line    = addr & ~addr_t'(LINE_BYTES - 1);
        reqs_before = mem_reqs;
        started     = 1'b1;
        i_req       = 1'b1;
        i_addr      = addr;
        @(negedge clk);
        i_req = 1'b0;
        while (!o_rsp_valid) begin
            @(negedge clk);
        end
        assert (mem_reqs == reqs_before + (exp_hit ? 0 : 1))
            else report_mismatch("memory requests per fetch", mem_reqs - reqs_before,
                                 exp_hit ? 0 : 1);
    endtask

    initial begin
        int n;
        arst      = 1'b1;
        i_req     = 1'b0;
        i_addr    = '0;
        exp_hit   = 1'b0;
        exp_instr = '0;
        exp_line  = '0;
        started   = 1'b0;
        misses    = 0;
        for (n = 0; n < SETS; n++) begin
            model_valid[n] = 1'b0;
            model_tag[n]   = '0;
        end
        // Small range of 64 lines so that sets conflict often.
        for (n = 0; n < STREAM_LEN; n++) begin
            stream[n] = 32'h0000_1000 | ($random(seed) & 32'h0000_03fc);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst = 1'b0;
        repeat (4) @(negedge clk);

        // Cold miss and then hits in the same line.
        fetch(32'h0000_1234);
        fetch(32'h0000_1234);
        fetch(32'h0000_123c);

        // Same set with a new tag and then the evicted line again.
        fetch(32'h0000_5234);
        fetch(32'h0000_1234);
        fetch(32'h0000_1230);

        for (n = 0; n < STREAM_LEN; n++) begin
            fetch(stream[n]);
        end

        assert (mem_reqs == misses)
            else report_mismatch("memory request total", mem_reqs, misses);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- icache.f
icache_pkg.sv
icache_req_reg.sv
icache_fsm.sv
icache_store.sv
icache_fill.sv
icache_top.sv
icache_chk.sv
icache_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = icache_tb
FILELIST  = icache.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
